// ==== tx_pkg.sv ====
package tx_pkg;

  // ********************
  // sizes
  // ********************

  localparam int QUEUE_NUM   = 8;
  localparam int QNUM_W      = $clog2(QUEUE_NUM);
  localparam int QINDEX_W    = 16;
  localparam int FRAME_LEN_W = 16;
  localparam int DMA_ADDR_W  = 32;
  localparam int MSIX_MSG_W  = 32;
  localparam int DATA_BYTES  = 8;
  localparam int DMA_DATA_W  = DATA_BYTES * 8;
  localparam int BYTE_SEL_W  = $clog2(DATA_BYTES);
  localparam int BYTE_CNT_W  = 16;
  localparam int DMA_HEAD_W  = DMA_ADDR_W + BYTE_CNT_W;
  localparam int STAT_CNT_W  = 32;

  typedef logic [QNUM_W-1:0]      qnum_t;
  typedef logic [QINDEX_W-1:0]    qindex_t;
  typedef logic [FRAME_LEN_W-1:0] frame_len_t;
  typedef logic [DMA_ADDR_W-1:0]  dma_addr_t;
  typedef logic [MSIX_MSG_W-1:0]  msix_msg_t;
  typedef logic [DMA_DATA_W-1:0]  dma_data_t;
  typedef logic [DATA_BYTES-1:0]  keep_t;
  typedef logic [BYTE_CNT_W-1:0]  byte_cnt_t;
  // address in 47:16, byte count in 15:0
  typedef logic [DMA_HEAD_W-1:0]  dma_head_t;
  typedef logic [STAT_CNT_W-1:0]  stat_cnt_t;

  // byte counts of the two write records
  localparam byte_cnt_t CPL_BYTES = 16'd8;
  localparam byte_cnt_t IRQ_BYTES = 16'd4;
  localparam keep_t     KEEP_ALL  = '1;

  // ********************
  // structs
  // ********************

  typedef struct packed {
    qnum_t      qnum;
    qindex_t    qindex;
    frame_len_t frame_len;
    dma_addr_t  frame_addr;
    dma_addr_t  cpl_addr;
    msix_msg_t  msix_msg;
    dma_addr_t  msix_addr;
  } tx_desc_t;

  typedef struct packed {
    dma_data_t data;
    dma_head_t head;
    logic      last;
  } dma_beat_t;

  typedef struct packed {
    dma_data_t data;
    keep_t     keep;
    logic      last;
    logic      start;
  } mac_beat_t;

  typedef enum logic [2:0] {
    st_idle,
    st_rd_req,
    st_stream,
    st_wr_back,
    st_finish
  } proc_state_t;

endpackage

// ==== tx_scheduler_rr.sv ====
`timescale 1ns/1ps

module tx_scheduler_rr (
  input  logic          clk,
  input  logic          reset,
  input  logic          start_sche,
  input  logic          tx_doorbell_valid,
  input  tx_pkg::qnum_t tx_doorbell_queue,
  output tx_pkg::qnum_t desc_req_qnum,
  output logic          desc_req_valid,
  input  logic          desc_req_ready
);

  logic [tx_pkg::QUEUE_NUM-1:0] pending;
  tx_pkg::qnum_t                last_served;
  tx_pkg::qnum_t                next_qnum;
  logic                         next_found;
  logic                         req_fire;

  assign req_fire = desc_req_valid && desc_req_ready;

  // search upward from the queue after the last one served
  always_comb begin
    tx_pkg::qnum_t idx;
    idx        = last_served;
    next_found = 1'b0;
    next_qnum  = '0;
    for (int i = 1; i <= tx_pkg::QUEUE_NUM; i++) begin
      idx = last_served + tx_pkg::qnum_t'(i);
      if (!next_found && pending[idx]) begin
        next_found = 1'b1;
        next_qnum  = idx;
      end
    end
  end

  // a doorbell wins over the clear and a repeated doorbell merges
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      if (req_fire) pending[desc_req_qnum] <= 1'b0;
      if (tx_doorbell_valid) pending[tx_doorbell_queue] <= 1'b1;
    end
  end

  // queue 0 goes first after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      desc_req_valid <= 1'b0;
      last_served    <= tx_pkg::qnum_t'(tx_pkg::QUEUE_NUM - 1);
    end else if (req_fire) begin
      desc_req_valid <= 1'b0;
      last_served    <= desc_req_qnum;
    end else if (!desc_req_valid && start_sche && next_found) begin
      desc_req_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!desc_req_valid) desc_req_qnum <= next_qnum;
  end

endmodule

// ==== tx_macproc.sv ====
`timescale 1ns/1ps

module tx_macproc (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 msix_enable,
  // descriptor response
  input  tx_pkg::tx_desc_t     desc,
  input  logic                 desc_valid,
  output logic                 desc_ready,
  // dma read
  output tx_pkg::dma_beat_t    frame_req,
  output logic                 frame_req_valid,
  input  logic                 frame_req_ready,
  input  tx_pkg::dma_beat_t    frame_rsp,
  input  logic                 frame_rsp_valid,
  output logic                 frame_rsp_ready,
  // mac transmit
  output tx_pkg::mac_beat_t    mac_tx,
  output logic                 mac_tx_valid,
  input  logic                 mac_tx_ready,
  // completion and interrupt writes
  output tx_pkg::dma_beat_t    cpl_wr,
  output logic                 cpl_wr_valid,
  input  logic                 cpl_wr_ready,
  output tx_pkg::dma_beat_t    irq_wr,
  output logic                 irq_wr_valid,
  input  logic                 irq_wr_ready,
  // finish report to queue manager
  output tx_pkg::qnum_t        cpl_finish_qnum,
  output logic                 cpl_finish_valid,
  input  logic                 cpl_finish_ready,
  output tx_pkg::stat_cnt_t    rec_cnt,
  output tx_pkg::stat_cnt_t    xmit_cnt,
  output tx_pkg::stat_cnt_t    cpl_cnt,
  output tx_pkg::stat_cnt_t    msix_cnt
);

  tx_pkg::proc_state_t           state;
  tx_pkg::tx_desc_t              desc_q;
  logic                          first_beat;
  logic                          cpl_done;
  logic                          irq_done;
  logic [tx_pkg::BYTE_SEL_W-1:0] tail_bytes;
  tx_pkg::keep_t                 last_keep;
  logic                          desc_fire;
  logic                          req_fire;
  logic                          beat_fire;
  logic                          cpl_fire;
  logic                          irq_fire;
  logic                          finish_fire;

  assign desc_fire   = desc_valid && desc_ready;
  assign req_fire    = frame_req_valid && frame_req_ready;
  assign beat_fire   = mac_tx_valid && mac_tx_ready;
  assign cpl_fire    = cpl_wr_valid && cpl_wr_ready;
  assign irq_fire    = irq_wr_valid && irq_wr_ready;
  assign finish_fire = cpl_finish_valid && cpl_finish_ready;

  // ********************
  // dma read request
  // ********************

  assign desc_ready      = (state == tx_pkg::st_idle);
  assign frame_req_valid = (state == tx_pkg::st_rd_req);
  assign frame_req.data  = '0;
  assign frame_req.head  = {desc_q.frame_addr, desc_q.frame_len};
  assign frame_req.last  = 1'b1;

  // ********************
  // response to mac
  // ********************

  // only the tail beat can be partial
  assign tail_bytes = desc_q.frame_len[tx_pkg::BYTE_SEL_W-1:0];
  assign last_keep  = (tail_bytes == '0) ? tx_pkg::KEEP_ALL : ~(tx_pkg::KEEP_ALL << tail_bytes);

  assign mac_tx_valid    = (state == tx_pkg::st_stream) && frame_rsp_valid;
  assign frame_rsp_ready = (state == tx_pkg::st_stream) && mac_tx_ready;
  assign mac_tx.data     = frame_rsp.data;
  assign mac_tx.keep     = frame_rsp.last ? last_keep : tx_pkg::KEEP_ALL;
  assign mac_tx.last     = frame_rsp.last;
  assign mac_tx.start    = first_beat;

  // ********************
  // write back
  // ********************

  assign cpl_wr_valid = (state == tx_pkg::st_wr_back) && !cpl_done;
  assign cpl_wr.data  = {16'h0, desc_q.frame_len, desc_q.qindex, 13'h0, desc_q.qnum};
  assign cpl_wr.head  = {desc_q.cpl_addr, tx_pkg::CPL_BYTES};
  assign cpl_wr.last  = 1'b1;

  assign irq_wr_valid = (state == tx_pkg::st_wr_back) && !irq_done;
  assign irq_wr.data  = {32'h0, desc_q.msix_msg};
  assign irq_wr.head  = {desc_q.msix_addr, tx_pkg::IRQ_BYTES};
  assign irq_wr.last  = 1'b1;

  assign cpl_finish_valid = (state == tx_pkg::st_finish);
  assign cpl_finish_qnum  = desc_q.qnum;

  always_ff @(posedge clk) begin
    if (desc_fire) desc_q <= desc;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= tx_pkg::st_idle;
      first_beat <= 1'b0;
      cpl_done   <= 1'b0;
      irq_done   <= 1'b0;
    end else begin
      case (state)
        tx_pkg::st_idle: begin
          if (desc_fire) state <= tx_pkg::st_rd_req;
        end
        tx_pkg::st_rd_req: begin
          if (req_fire) begin
            state      <= tx_pkg::st_stream;
            first_beat <= 1'b1;
          end
        end
        tx_pkg::st_stream: begin
          if (beat_fire) begin
            first_beat <= 1'b0;
            if (frame_rsp.last) begin
              state    <= tx_pkg::st_wr_back;
              cpl_done <= 1'b0;
              // no interrupt owed when msix is off
              irq_done <= !msix_enable;
            end
          end
        end
        tx_pkg::st_wr_back: begin
          if (cpl_fire) cpl_done <= 1'b1;
          if (irq_fire) irq_done <= 1'b1;
          if ((cpl_done || cpl_fire) && (irq_done || irq_fire)) state <= tx_pkg::st_finish;
        end
        tx_pkg::st_finish: begin
          if (finish_fire) state <= tx_pkg::st_idle;
        end
        default: state <= tx_pkg::st_idle;
      endcase
    end
  end

  // statistics
  always_ff @(posedge clk) begin
    if (reset) begin
      rec_cnt  <= '0;
      xmit_cnt <= '0;
      cpl_cnt  <= '0;
      msix_cnt <= '0;
    end else begin
      if (desc_fire) rec_cnt <= rec_cnt + 1'b1;
      if (beat_fire && frame_rsp.last) xmit_cnt <= xmit_cnt + 1'b1;
      if (cpl_fire) cpl_cnt <= cpl_cnt + 1'b1;
      if (irq_fire) msix_cnt <= msix_cnt + 1'b1;
    end
  end

endmodule

// ==== tx_wr_arbiter.sv ====
`timescale 1ns/1ps

module tx_wr_arbiter (
  input  logic              clk,
  input  logic              reset,
  input  tx_pkg::dma_beat_t cpl_wr,
  input  logic              cpl_wr_valid,
  output logic              cpl_wr_ready,
  input  tx_pkg::dma_beat_t irq_wr,
  input  logic              irq_wr_valid,
  output logic              irq_wr_ready,
  output tx_pkg::dma_beat_t dma_wr,
  output logic              dma_wr_valid,
  input  logic              dma_wr_ready
);

  logic              last_irq;
  logic              locked;
  logic              sel_irq;
  logic              in_valid;
  logic              can_load;
  tx_pkg::dma_beat_t in_beat;

  // inside a packet the last winner keeps the grant
  always_comb begin
    if (locked) begin
      sel_irq = last_irq;
    end else if (cpl_wr_valid && irq_wr_valid) begin
      sel_irq = !last_irq;
    end else begin
      sel_irq = irq_wr_valid;
    end
  end

  assign in_valid     = sel_irq ? irq_wr_valid : cpl_wr_valid;
  assign in_beat      = sel_irq ? irq_wr : cpl_wr;
  // output register is empty or drains this cycle
  assign can_load     = !dma_wr_valid || dma_wr_ready;
  assign cpl_wr_ready = can_load && !sel_irq;
  assign irq_wr_ready = can_load && sel_irq;

  // last_irq starts set so completion wins the first tie
  always_ff @(posedge clk) begin
    if (reset) begin
      dma_wr_valid <= 1'b0;
      last_irq     <= 1'b1;
      locked       <= 1'b0;
    end else if (can_load) begin
      dma_wr_valid <= in_valid;
      if (in_valid) begin
        last_irq <= sel_irq;
        locked   <= !in_beat.last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_load && in_valid) dma_wr <= in_beat;
  end

endmodule

// ==== tx_mac_engine.sv ====
`timescale 1ns/1ps

module tx_mac_engine (
  input  logic              clk,
  input  logic              reset,
  input  logic              start_sche,
  input  logic              msix_enable,
  // doorbell from host
  input  logic              tx_doorbell_valid,
  input  tx_pkg::qnum_t     tx_doorbell_queue,
  // descriptor provider
  output tx_pkg::qnum_t     desc_req_qnum,
  output logic              desc_req_valid,
  input  logic              desc_req_ready,
  input  tx_pkg::tx_desc_t  desc,
  input  logic              desc_valid,
  output logic              desc_ready,
  // dma read
  output tx_pkg::dma_beat_t frame_req,
  output logic              frame_req_valid,
  input  logic              frame_req_ready,
  input  tx_pkg::dma_beat_t frame_rsp,
  input  logic              frame_rsp_valid,
  output logic              frame_rsp_ready,
  // mac
  output tx_pkg::mac_beat_t mac_tx,
  output logic              mac_tx_valid,
  input  logic              mac_tx_ready,
  // merged dma write
  output tx_pkg::dma_beat_t dma_wr,
  output logic              dma_wr_valid,
  input  logic              dma_wr_ready,
  // queue manager
  output tx_pkg::qnum_t     cpl_finish_qnum,
  output logic              cpl_finish_valid,
  input  logic              cpl_finish_ready,
  output tx_pkg::stat_cnt_t rec_cnt,
  output tx_pkg::stat_cnt_t xmit_cnt,
  output tx_pkg::stat_cnt_t cpl_cnt,
  output tx_pkg::stat_cnt_t msix_cnt
);

  // ********************
  // internal write streams
  // ********************

  tx_pkg::dma_beat_t cpl_wr;
  logic              cpl_wr_valid;
  logic              cpl_wr_ready;
  tx_pkg::dma_beat_t irq_wr;
  logic              irq_wr_valid;
  logic              irq_wr_ready;

  tx_scheduler_rr i_tx_scheduler_rr (
    .clk               (clk),
    .reset             (reset),
    .start_sche        (start_sche),
    .tx_doorbell_valid (tx_doorbell_valid),
    .tx_doorbell_queue (tx_doorbell_queue),
    .desc_req_qnum     (desc_req_qnum),
    .desc_req_valid    (desc_req_valid),
    .desc_req_ready    (desc_req_ready)
  );

  tx_macproc i_tx_macproc (
    .clk              (clk),
    .reset            (reset),
    .msix_enable      (msix_enable),
    .desc             (desc),
    .desc_valid       (desc_valid),
    .desc_ready       (desc_ready),
    .frame_req        (frame_req),
    .frame_req_valid  (frame_req_valid),
    .frame_req_ready  (frame_req_ready),
    .frame_rsp        (frame_rsp),
    .frame_rsp_valid  (frame_rsp_valid),
    .frame_rsp_ready  (frame_rsp_ready),
    .mac_tx           (mac_tx),
    .mac_tx_valid     (mac_tx_valid),
    .mac_tx_ready     (mac_tx_ready),
    .cpl_wr           (cpl_wr),
    .cpl_wr_valid     (cpl_wr_valid),
    .cpl_wr_ready     (cpl_wr_ready),
    .irq_wr           (irq_wr),
    .irq_wr_valid     (irq_wr_valid),
    .irq_wr_ready     (irq_wr_ready),
    .cpl_finish_qnum  (cpl_finish_qnum),
    .cpl_finish_valid (cpl_finish_valid),
    .cpl_finish_ready (cpl_finish_ready),
    .rec_cnt          (rec_cnt),
    .xmit_cnt         (xmit_cnt),
    .cpl_cnt          (cpl_cnt),
    .msix_cnt         (msix_cnt)
  );

  tx_wr_arbiter i_tx_wr_arbiter (
    .clk          (clk),
    .reset        (reset),
    .cpl_wr       (cpl_wr),
    .cpl_wr_valid (cpl_wr_valid),
    .cpl_wr_ready (cpl_wr_ready),
    .irq_wr       (irq_wr),
    .irq_wr_valid (irq_wr_valid),
    .irq_wr_ready (irq_wr_ready),
    .dma_wr       (dma_wr),
    .dma_wr_valid (dma_wr_valid),
    .dma_wr_ready (dma_wr_ready)
  );

endmodule

// ==== tb_tx_mac_engine.sv ====
`timescale 1ns/1ps

module tb_tx_mac_engine;

  localparam int TIMEOUT_CYCLES = 4000;

  logic              clk = 1'b0;
  logic              reset = 1'b1;
  logic              start_sche = 1'b0;
  logic              msix_enable = 1'b0;
  logic              tx_doorbell_valid = 1'b0;
  tx_pkg::qnum_t     tx_doorbell_queue = '0;
  tx_pkg::qnum_t     desc_req_qnum;
  logic              desc_req_valid;
  logic              desc_req_ready = 1'b0;
  tx_pkg::tx_desc_t  desc = '0;
  logic              desc_valid = 1'b0;
  logic              desc_ready;
  tx_pkg::dma_beat_t frame_req;
  logic              frame_req_valid;
  logic              frame_req_ready = 1'b0;
  tx_pkg::dma_beat_t frame_rsp = '0;
  logic              frame_rsp_valid = 1'b0;
  logic              frame_rsp_ready;
  tx_pkg::mac_beat_t mac_tx;
  logic              mac_tx_valid;
  logic              mac_tx_ready = 1'b0;
  tx_pkg::dma_beat_t dma_wr;
  logic              dma_wr_valid;
  logic              dma_wr_ready = 1'b0;
  tx_pkg::qnum_t     cpl_finish_qnum;
  logic              cpl_finish_valid;
  logic              cpl_finish_ready = 1'b0;
  tx_pkg::stat_cnt_t rec_cnt;
  tx_pkg::stat_cnt_t xmit_cnt;
  tx_pkg::stat_cnt_t cpl_cnt;
  tx_pkg::stat_cnt_t msix_cnt;

  logic [31:0]       stim [0:127];
  logic [31:0]       rng = 32'h48b9_0817;
  int                cycle = 0;
  int                n_errors = 0;
  int                mac_total = 0;
  int                wr_total = 0;
  tx_pkg::qnum_t     exp_q[$];
  tx_pkg::qnum_t     fin_q[$];
  int                fin_cyc_q[$];
  int                cpl_cyc_q[$];
  int                irq_cyc_q[$];
  tx_pkg::mac_beat_t mac_q[$];
  tx_pkg::dma_beat_t wr_q[$];
  tx_pkg::dma_addr_t rd_addr = '0;
  int                rd_len = 0;
  int                rd_off = 0;
  logic              rd_active = 1'b0;

  tx_mac_engine i_tx_mac_engine (.*);

  initial begin
    forever #20 clk = ~clk;
  end

  // ********************
  // reference rules
  // ********************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // six words per queue after the msix_enable word
  function automatic tx_pkg::tx_desc_t desc_of(input int q);
    tx_pkg::tx_desc_t d;
    int               base;
    base         = 1 + q * 6;
    d.qnum       = tx_pkg::qnum_t'(q);
    d.qindex     = stim[base][15:0];
    d.frame_len  = stim[base + 1][15:0];
    d.frame_addr = stim[base + 2];
    d.cpl_addr   = stim[base + 3];
    d.msix_msg   = stim[base + 4];
    d.msix_addr  = stim[base + 5];
    return d;
  endfunction

  // host memory holds the low address byte at every location
  function automatic tx_pkg::dma_data_t pattern_data(input tx_pkg::dma_addr_t addr, input int off);
    tx_pkg::dma_data_t d;
    for (int i = 0; i < tx_pkg::DATA_BYTES; i++) begin
      d[8*i +: 8] = 8'(addr + tx_pkg::dma_addr_t'(off + i));
    end
    return d;
  endfunction

  function automatic tx_pkg::keep_t tail_keep(input int len);
    int rem;
    rem = len % tx_pkg::DATA_BYTES;
    if (rem == 0) return 8'hff;
    return tx_pkg::keep_t'((1 << rem) - 1);
  endfunction

  function automatic tx_pkg::dma_beat_t cpl_beat(input tx_pkg::tx_desc_t d);
    tx_pkg::dma_beat_t b;
    b             = '0;
    b.data[2:0]   = d.qnum;
    b.data[31:16] = d.qindex;
    b.data[47:32] = d.frame_len;
    b.head        = {d.cpl_addr, 16'd8};
    b.last        = 1'b1;
    return b;
  endfunction

  function automatic tx_pkg::dma_beat_t irq_beat(input tx_pkg::tx_desc_t d);
    tx_pkg::dma_beat_t b;
    b            = '0;
    b.data[31:0] = d.msix_msg;
    b.head       = {d.msix_addr, 16'd4};
    b.last       = 1'b1;
    return b;
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] exp_val,
                                 input logic [127:0] act_val);
    n_errors++;
    $display("** Error %s: expected %0h, actual %0h", name, exp_val, act_val);
  endtask

  // ********************
  // outside models
  // ********************

  always @(posedge clk) begin
    rng   <= xorshift32(rng);
    cycle <= cycle + 1;
  end

  // descriptor provider keeps one descriptor outstanding at a time
  always @(posedge clk) begin
    if (reset) begin
      desc_req_ready <= 1'b0;
      desc_valid     <= 1'b0;
    end else begin
      if (desc_valid && desc_ready) desc_valid <= 1'b0;
      if (desc_req_valid && desc_req_ready) begin
        desc           <= desc_of(int'(desc_req_qnum));
        desc_valid     <= 1'b1;
        desc_req_ready <= 1'b0;
      end else begin
        desc_req_ready <= rng[0] && (!desc_valid || desc_ready);
      end
    end
  end

  // dma read model with random gaps between response beats
  always @(posedge clk) begin
    if (reset) begin
      frame_req_ready <= 1'b0;
      frame_rsp_valid <= 1'b0;
      rd_active       <= 1'b0;
    end else begin
      frame_req_ready <= rng[1] && !rd_active;
      if (frame_req_valid && frame_req_ready) begin
        // a read request is a single beat
        if (frame_req.last != 1'b1) begin
          report_mismatch("frame_req_last", 128'(1), 128'(frame_req.last));
        end
        rd_addr         <= frame_req.head[47:16];
        rd_len          <= int'(frame_req.head[15:0]);
        rd_off          <= 0;
        rd_active       <= 1'b1;
        frame_req_ready <= 1'b0;
      end
      if (frame_rsp_valid && frame_rsp_ready) begin
        frame_rsp_valid <= 1'b0;
        rd_off          <= rd_off + tx_pkg::DATA_BYTES;
        if (frame_rsp.last) rd_active <= 1'b0;
      end else if (rd_active && !frame_rsp_valid && rng[2]) begin
        frame_rsp.data  <= pattern_data(rd_addr, rd_off);
        frame_rsp.head  <= '0;
        frame_rsp.last  <= (rd_off + tx_pkg::DATA_BYTES >= rd_len);
        frame_rsp_valid <= 1'b1;
      end
    end
  end

  // mac, dma write and queue manager sinks
  always @(posedge clk) begin
    if (reset) begin
      mac_tx_ready     <= 1'b0;
      dma_wr_ready     <= 1'b0;
      cpl_finish_ready <= 1'b0;
    end else begin
      mac_tx_ready     <= rng[3] | rng[4];
      dma_wr_ready     <= rng[5] | rng[6];
      cpl_finish_ready <= rng[7];
      if (mac_tx_valid && mac_tx_ready) begin
        mac_q.push_back(mac_tx);
        mac_total <= mac_total + 1;
      end
      if (dma_wr_valid && dma_wr_ready) begin
        wr_q.push_back(dma_wr);
        wr_total <= wr_total + 1;
      end
      if (cpl_finish_valid && cpl_finish_ready) begin
        fin_q.push_back(cpl_finish_qnum);
        fin_cyc_q.push_back(cycle);
      end
      // internal write handshakes give the order against the finish report
      if (i_tx_mac_engine.cpl_wr_valid && i_tx_mac_engine.cpl_wr_ready) cpl_cyc_q.push_back(cycle);
      if (i_tx_mac_engine.irq_wr_valid && i_tx_mac_engine.irq_wr_ready) irq_cyc_q.push_back(cycle);
    end
  end

  // ********************
  // test sequence
  // ********************

  initial begin
    int                idx;
    int                n;
    int                to;
    int                len;
    int                nbeats;
    int                wr_per_frame;
    int                cpl_seen;
    int                irq_seen;
    logic              timed_out;
    tx_pkg::tx_desc_t  d;
    tx_pkg::mac_beat_t mb;
    tx_pkg::dma_beat_t wb;

    timed_out = 1'b0;
    $readmemh("tx_engine_input.txt", stim);
    @(posedge clk);
    msix_enable <= stim[0][0];
    repeat (7) @(posedge clk);
    reset <= 1'b0;
    wr_per_frame = stim[0][0] ? 2 : 1;

    idx = 1 + tx_pkg::QUEUE_NUM * 6;
    while (stim[idx] != 0 && !timed_out) begin
      n = int'(stim[idx]);
      idx++;
      for (int i = 0; i < n; i++) begin
        @(posedge clk);
        tx_doorbell_valid <= 1'b1;
        tx_doorbell_queue <= tx_pkg::qnum_t'(stim[idx]);
        idx++;
      end
      @(posedge clk);
      tx_doorbell_valid <= 1'b0;
      // start_sche is low, so no request may appear
      for (int i = 0; i < 6; i++) begin
        @(negedge clk);
        if (desc_req_valid) report_mismatch("sched_hold", 128'(0), 128'(desc_req_valid));
      end
      n = int'(stim[idx]);
      idx++;
      for (int i = 0; i < n; i++) begin
        exp_q.push_back(tx_pkg::qnum_t'(stim[idx]));
        idx++;
      end
      @(posedge clk);
      start_sche <= 1'b1;
      to = 0;
      while (fin_q.size() < exp_q.size() && to < TIMEOUT_CYCLES) begin
        @(negedge clk);
        to++;
      end
      if (fin_q.size() < exp_q.size()) begin
        $display("timeout: finish reports for a batch never arrived");
        timed_out = 1'b1;
        n_errors++;
      end
      @(posedge clk);
      start_sche <= 1'b0;
    end

    to = 0;
    while (wr_q.size() < exp_q.size() * wr_per_frame && to < TIMEOUT_CYCLES) begin
      @(negedge clk);
      to++;
    end
    if (wr_q.size() < exp_q.size() * wr_per_frame) begin
      $display("timeout: dma write stream did not deliver all writes");
      n_errors++;
    end

    for (int k = 0; k < exp_q.size(); k++) begin
      d      = desc_of(int'(exp_q[k]));
      len    = int'(d.frame_len);
      nbeats = (len + tx_pkg::DATA_BYTES - 1) / tx_pkg::DATA_BYTES;
      if (k < fin_q.size() && fin_q[k] != exp_q[k]) begin
        report_mismatch("finish_qnum", 128'(exp_q[k]), 128'(fin_q[k]));
      end
      for (int b = 0; b < nbeats; b++) begin
        if (mac_q.size() == 0) begin
          report_mismatch("mac_beat_count", 128'(nbeats), 128'(b));
          break;
        end
        mb = mac_q.pop_front();
        if (mb.data != pattern_data(d.frame_addr, b * tx_pkg::DATA_BYTES)) begin
          report_mismatch("mac_data", 128'(pattern_data(d.frame_addr, b * 8)), 128'(mb.data));
        end
        if (mb.start != (b == 0)) report_mismatch("mac_start", 128'(b == 0), 128'(mb.start));
        if (mb.last != (b == nbeats - 1)) begin
          report_mismatch("mac_last", 128'(b == nbeats - 1), 128'(mb.last));
        end
        if (mb.keep != ((b == nbeats - 1) ? tail_keep(len) : 8'hff)) begin
          report_mismatch("mac_keep", 128'((b == nbeats - 1) ? tail_keep(len) : 8'hff),
                          128'(mb.keep));
        end
      end
      // completion and interrupt may leave in either order within a frame
      cpl_seen = 0;
      irq_seen = 0;
      for (int w = 0; w < wr_per_frame; w++) begin
        if (wr_q.size() == 0) begin
          report_mismatch("dma_wr_count", 128'(wr_per_frame), 128'(w));
          break;
        end
        wb = wr_q.pop_front();
        if (wb == cpl_beat(d)) begin
          cpl_seen++;
        end else if (wr_per_frame == 2 && wb == irq_beat(d)) begin
          irq_seen++;
        end else begin
          report_mismatch("dma_wr", 128'(cpl_beat(d)), 128'(wb));
        end
      end
      if (cpl_seen != 1) report_mismatch("cpl_wr_per_frame", 128'(1), 128'(cpl_seen));
      if (wr_per_frame == 2 && irq_seen != 1) begin
        report_mismatch("irq_wr_per_frame", 128'(1), 128'(irq_seen));
      end
      if (k < fin_cyc_q.size() && k < cpl_cyc_q.size() && fin_cyc_q[k] <= cpl_cyc_q[k]) begin
        report_mismatch("finish_after_cpl", 128'(cpl_cyc_q[k] + 1), 128'(fin_cyc_q[k]));
      end
      if (wr_per_frame == 2 && k < fin_cyc_q.size() && k < irq_cyc_q.size() &&
          fin_cyc_q[k] <= irq_cyc_q[k]) begin
        report_mismatch("finish_after_irq", 128'(irq_cyc_q[k] + 1), 128'(fin_cyc_q[k]));
      end
    end

    if (mac_q.size() != 0) report_mismatch("mac_extra_beats", 128'(0), 128'(mac_q.size()));
    if (wr_q.size() != 0) report_mismatch("dma_wr_extra", 128'(0), 128'(wr_q.size()));
    if (fin_q.size() != exp_q.size()) begin
      report_mismatch("finish_count", 128'(exp_q.size()), 128'(fin_q.size()));
    end
    if (rec_cnt != tx_pkg::stat_cnt_t'(exp_q.size())) begin
      report_mismatch("rec_cnt", 128'(exp_q.size()), 128'(rec_cnt));
    end
    if (xmit_cnt != tx_pkg::stat_cnt_t'(exp_q.size())) begin
      report_mismatch("xmit_cnt", 128'(exp_q.size()), 128'(xmit_cnt));
    end
    if (cpl_cnt != tx_pkg::stat_cnt_t'(exp_q.size())) begin
      report_mismatch("cpl_cnt", 128'(exp_q.size()), 128'(cpl_cnt));
    end
    if (msix_cnt != tx_pkg::stat_cnt_t'(exp_q.size() * (wr_per_frame - 1))) begin
      report_mismatch("msix_cnt", 128'(exp_q.size() * (wr_per_frame - 1)), 128'(msix_cnt));
    end

    $display("frames %0d, mac beats %0d, dma writes %0d, errors %0d",
             exp_q.size(), mac_total, wr_total, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tx_mac_engine.f ====
tx_pkg.sv
tx_scheduler_rr.sv
tx_macproc.sv
tx_wr_arbiter.sv
tx_mac_engine.sv
tb_tx_mac_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the tx_mac_engine testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_tx_mac_engine \
  -f tx_mac_engine.f \
  -o sim_tx_mac_engine

./obj_dir/sim_tx_mac_engine | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0

// ==== tx_engine_input.txt ====
// word 0 is msix_enable, then one line per queue 0..7 with
// qindex frame_len frame_addr cpl_addr msix_msg msix_addr
1
0010 0040 10000000 20000000 00000a00 fee00000
0021 0013 10001003 20000010 00000a01 fee00004
0032 0001 100020ff 20000020 00000a02 fee00008
0043 002f 10003010 20000030 00000a03 fee0000c
0054 0008 10004080 20000040 00000a04 fee00010
0065 0021 100050fa 20000050 00000a05 fee00014
0076 003e 10006001 20000060 00000a06 fee00018
0087 000c 10007abc 20000070 00000a07 fee0001c
// batches: doorbell count and queues, then served count and expected order
// batch 1 with queue 2 rung twice, served from queue 0 upward
4 2 5 2 7
3 2 5 7
// batch 2, search starts after queue 7
3 6 1 3
3 1 3 6
// batch 3, wraps from queue 7 to 0
4 5 7 0 7
3 7 0 5
// end of batches
0
